/* source/fetch_macros.svh */
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// Instruction queue entries, power of two
`define IQ_DEPTH 4

// Counter table index width and lowest pc bit used
`define BHT_IDX_W 4
`define BHT_LSB 2

`define RESET_PC 32'h0000_0000

`endif

/* source/fetch_pkg.sv */
`default_nettype none

`include "fetch_macros.svh"

package fetch_pkg;

    typedef logic [31:0] word_t;

    typedef logic [`BHT_IDX_W-1:0] bht_idx_t;

    // Saturating counter, upper half predicts taken
    typedef logic [1:0] ctr_t;

    // Extra top bit tells full from empty
    typedef logic [$clog2(`IQ_DEPTH):0] iq_ptr_t;

    typedef enum logic [6:0] {
        OP_JAL    = 7'b1101111,
        OP_BRANCH = 7'b1100011,
        OP_OTHER  = 7'b0000000
    } opcode_e;

    typedef enum logic [1:0] {
        ST_REQ,
        ST_WAIT,
        ST_HOLD,
        ST_DROP
    } fetch_state_e;

endpackage

`default_nettype wire

/* source/iq_entry_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface iq_entry_if;

    import fetch_pkg::*;

    logic  valid;
    logic  ready;
    word_t pc;
    word_t next_pc;
    word_t instr;
    logic  pred_taken;

    modport sender (
        output valid, pc, next_pc, instr, pred_taken,
        input  ready
    );

    modport receiver (
        input  valid, pc, next_pc, instr, pred_taken,
        output ready
    );

endinterface

`default_nettype wire

/* source/pred_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface pred_if;

    import fetch_pkg::*;

    word_t pc;
    word_t instr;
    logic  taken;
    word_t target;

    modport requester (
        output pc, instr,
        input  taken, target
    );

    modport responder (
        input  pc, instr,
        output taken, target
    );

endinterface

`default_nettype wire

/* source/fetch_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_ctrl (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_redirect_valid,
    input  fetch_pkg::word_t i_redirect_pc,
    output logic             o_imem_req,
    output fetch_pkg::word_t o_imem_addr,
    input  logic             i_imem_valid,
    input  fetch_pkg::word_t i_imem_rdata,
    pred_if.requester        pred,
    iq_entry_if.sender       iq
);

    import fetch_pkg::*;

    fetch_state_e state;
    word_t        pc_q;
    word_t        next_pc_q;
    word_t        instr_q;
    logic         taken_q;
    logic         xfer;
    logic         in_flight;

    assign xfer      = iq.valid && iq.ready;
    assign in_flight = (state == ST_WAIT) || (state == ST_DROP);

    // No read is launched on a redirect edge, its pc is already stale
    assign o_imem_req  = (state == ST_REQ) && !i_redirect_valid;
    assign o_imem_addr = pc_q;

    // Predictor looks at the word as it returns
    assign pred.pc    = pc_q;
    assign pred.instr = i_imem_rdata;

    assign iq.valid      = (state == ST_HOLD);
    assign iq.pc         = pc_q;
    assign iq.next_pc    = next_pc_q;
    assign iq.instr      = instr_q;
    assign iq.pred_taken = taken_q;

    // ========================================
    // Request sequencing
    // ========================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= ST_REQ;
            pc_q  <= `RESET_PC;
        end else if (i_redirect_valid) begin
            pc_q <= i_redirect_pc;
            // Outstanding response still has to be swallowed
            if (in_flight && !i_imem_valid) begin
                state <= ST_DROP;
            end else begin
                state <= ST_REQ;
            end
        end else begin
            case (state)
                ST_REQ: begin
                    state <= ST_WAIT;
                end
                ST_WAIT: begin
                    if (i_imem_valid) begin
                        state <= ST_HOLD;
                    end
                end
                ST_HOLD: begin
                    if (xfer) begin
                        pc_q  <= next_pc_q;
                        state <= ST_REQ;
                    end
                end
                ST_DROP: begin
                    if (i_imem_valid) begin
                        state <= ST_REQ;
                    end
                end
                default: begin
                    state <= ST_REQ;
                end
            endcase
        end
    end

    // Entry payload, captured on the response edge
    always_ff @(posedge i_clk) begin
        if (state == ST_WAIT && i_imem_valid) begin
            instr_q   <= i_imem_rdata;
            taken_q   <= pred.taken;
            next_pc_q <= pred.taken ? pred.target : pc_q + 32'd4;
        end
    end

endmodule

`default_nettype wire

/* source/branch_predictor.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fetch_macros.svh"

module branch_predictor (
    input  logic             i_clk,
    input  logic             i_rst_n,
    pred_if.responder        pred,
    input  logic             i_bu_valid,
    input  fetch_pkg::word_t i_bu_pc,
    input  logic             i_bu_taken
);

    import fetch_pkg::*;

    localparam int BHT_SIZE = 1 << `BHT_IDX_W;

    ctr_t     bht [BHT_SIZE];
    opcode_e  opcode;
    word_t    imm_j;
    word_t    imm_b;
    bht_idx_t rd_idx;
    bht_idx_t up_idx;
    ctr_t     up_ctr;

    // ========================================
    // Decode
    // ========================================
    always_comb begin
        case (pred.instr[6:0])
            OP_JAL:    opcode = OP_JAL;
            OP_BRANCH: opcode = OP_BRANCH;
            default:   opcode = OP_OTHER;
        endcase
    end

    assign imm_j = {{12{pred.instr[31]}}, pred.instr[19:12], pred.instr[20],
                    pred.instr[30:21], 1'b0};
    assign imm_b = {{20{pred.instr[31]}}, pred.instr[7], pred.instr[30:25],
                    pred.instr[11:8], 1'b0};

    assign rd_idx = pred.pc[`BHT_LSB +: `BHT_IDX_W];

    always_comb begin
        pred.taken  = 1'b0;
        pred.target = pred.pc + 32'd4;
        case (opcode)
            OP_JAL: begin
                pred.taken  = 1'b1;
                pred.target = pred.pc + imm_j;
            end
            OP_BRANCH: begin
                // Counter values 2 and 3 have the top bit set
                pred.taken  = bht[rd_idx][1];
                pred.target = pred.pc + imm_b;
            end
            default: begin
                pred.taken = 1'b0;
            end
        endcase
    end

    // ========================================
    // Counter training
    // ========================================
    assign up_idx = i_bu_pc[`BHT_LSB +: `BHT_IDX_W];
    assign up_ctr = bht[up_idx];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < BHT_SIZE; i++) begin
                bht[i] <= ctr_t'(1);
            end
        end else if (i_bu_valid) begin
            if (i_bu_taken && up_ctr != 2'd3) begin
                bht[up_idx] <= up_ctr + 2'd1;
            end else if (!i_bu_taken && up_ctr != 2'd0) begin
                bht[up_idx] <= up_ctr - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/instr_queue.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fetch_macros.svh"

module instr_queue (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_flush,
    iq_entry_if.receiver     wr,
    output logic             o_valid,
    input  logic             i_ready,
    output fetch_pkg::word_t o_pc,
    output fetch_pkg::word_t o_next_pc,
    output fetch_pkg::word_t o_instr,
    output logic             o_pred_taken
);

    import fetch_pkg::*;

    localparam int AW = $clog2(`IQ_DEPTH);

    word_t   pc_mem    [`IQ_DEPTH];
    word_t   next_mem  [`IQ_DEPTH];
    word_t   instr_mem [`IQ_DEPTH];
    logic    taken_mem [`IQ_DEPTH];
    iq_ptr_t wr_ptr;
    iq_ptr_t rd_ptr;
    logic    full;
    logic    empty;
    logic    push;
    logic    pop;

    // Same slot with different wrap bits means full
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign wr.ready = !full;
    assign push     = wr.valid && wr.ready;
    assign o_valid  = !empty;
    assign pop      = o_valid && i_ready;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (i_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (push) begin
            pc_mem[wr_ptr[AW-1:0]]    <= wr.pc;
            next_mem[wr_ptr[AW-1:0]]  <= wr.next_pc;
            instr_mem[wr_ptr[AW-1:0]] <= wr.instr;
            taken_mem[wr_ptr[AW-1:0]] <= wr.pred_taken;
        end
    end

    assign o_pc         = pc_mem[rd_ptr[AW-1:0]];
    assign o_next_pc    = next_mem[rd_ptr[AW-1:0]];
    assign o_instr      = instr_mem[rd_ptr[AW-1:0]];
    assign o_pred_taken = taken_mem[rd_ptr[AW-1:0]];

endmodule

`default_nettype wire

/* source/ifetch_top.sv */
`timescale 1ns/100ps
`default_nettype none

module ifetch_top (
    input  logic             i_clk,
    input  logic             i_rst_n,

    // Back-end redirect
    input  logic             i_redirect_valid,
    input  fetch_pkg::word_t i_redirect_pc,

    // Instruction memory
    output logic             o_imem_req,
    output fetch_pkg::word_t o_imem_addr,
    input  logic             i_imem_valid,
    input  fetch_pkg::word_t i_imem_rdata,

    // Decoder side
    output logic             o_iq_valid,
    input  logic             i_iq_ready,
    output fetch_pkg::word_t o_iq_pc,
    output fetch_pkg::word_t o_iq_next_pc,
    output fetch_pkg::word_t o_iq_instr,
    output logic             o_iq_pred_taken,

    // Branch outcomes from the reorder buffer
    input  logic             i_bu_valid,
    input  fetch_pkg::word_t i_bu_pc,
    input  logic             i_bu_taken
);

    iq_entry_if iq_bus ();
    pred_if     pred_bus ();

    fetch_ctrl u_fetch_ctrl (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_redirect_valid (i_redirect_valid),
        .i_redirect_pc    (i_redirect_pc),
        .o_imem_req       (o_imem_req),
        .o_imem_addr      (o_imem_addr),
        .i_imem_valid     (i_imem_valid),
        .i_imem_rdata     (i_imem_rdata),
        .pred             (pred_bus.requester),
        .iq               (iq_bus.sender)
    );

    branch_predictor u_branch_predictor (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .pred       (pred_bus.responder),
        .i_bu_valid (i_bu_valid),
        .i_bu_pc    (i_bu_pc),
        .i_bu_taken (i_bu_taken)
    );

    // Redirect also empties the queue
    instr_queue u_instr_queue (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_flush      (i_redirect_valid),
        .wr           (iq_bus.receiver),
        .o_valid      (o_iq_valid),
        .i_ready      (i_iq_ready),
        .o_pc         (o_iq_pc),
        .o_next_pc    (o_iq_next_pc),
        .o_instr      (o_iq_instr),
        .o_pred_taken (o_iq_pred_taken)
    );

endmodule

`default_nettype wire

/* bench/tb_ifetch.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fetch_macros.svh"

module tb_ifetch;

    import fetch_pkg::*;

    typedef struct {
        string kind;
        string name;
        word_t a;
        word_t b;
        word_t c;
        word_t d;
    } cmd_t;

    logic  clk;
    logic  rst_n;
    logic  redirect_valid;
    word_t redirect_pc;
    logic  imem_req;
    word_t imem_addr;
    logic  imem_valid;
    word_t imem_rdata;
    logic  iq_valid;
    logic  iq_ready;
    word_t iq_pc;
    word_t iq_next_pc;
    word_t iq_instr;
    logic  iq_pred_taken;
    logic  bu_valid;
    word_t bu_pc;
    logic  bu_taken;

    word_t       mem [word_t];
    cmd_t        cmds [$];
    logic [1:0]  ref_ctr [1 << `BHT_IDX_W];
    logic [31:0] lfsr = 32'hfef39d6b;
    string       test_name;
    int          test_errs;
    int          test_checks;
    int          total_errs;
    int          tests_run;
    int          tests_bad;
    int          cycles;
    int          limit = 1000000;
    int          mem_wait;
    logic        mem_busy;
    word_t       mem_addr;

    ifetch_top dut0 (
        .i_clk            (clk),
        .i_rst_n          (rst_n),
        .i_redirect_valid (redirect_valid),
        .i_redirect_pc    (redirect_pc),
        .o_imem_req       (imem_req),
        .o_imem_addr      (imem_addr),
        .i_imem_valid     (imem_valid),
        .i_imem_rdata     (imem_rdata),
        .o_iq_valid       (iq_valid),
        .i_iq_ready       (iq_ready),
        .o_iq_pc          (iq_pc),
        .o_iq_next_pc     (iq_next_pc),
        .o_iq_instr       (iq_instr),
        .o_iq_pred_taken  (iq_pred_taken),
        .i_bu_valid       (bu_valid),
        .i_bu_pc          (bu_pc),
        .i_bu_taken       (bu_taken)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic next_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    // Unlisted addresses read as addi words tagged with the address
    function automatic word_t mem_read(word_t addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        // Bits outside the tag field are folded into it
        return {addr[26:2] ^ {addr[1:0], 18'd0, addr[31:27]}, 7'h13};
    endfunction

    // ========================================
    // Memory model with 1 to 4 cycle latency
    // ========================================
    always @(posedge clk or negedge rst_n) begin
        logic [1:0] dly;
        if (!rst_n) begin
            imem_valid <= 1'b0;
            mem_busy = 1'b0;
        end else begin
            imem_valid <= 1'b0;
            if (imem_req && mem_busy) begin
                $display("%s: memory request issued while a read was outstanding",
                         test_name);
                test_errs++;
            end
            if (mem_busy) begin
                if (mem_wait <= 1) begin
                    imem_valid <= 1'b1;
                    imem_rdata <= mem_read(mem_addr);
                    mem_busy = 1'b0;
                end else begin
                    mem_wait = mem_wait - 1;
                end
            end else if (imem_req) begin
                dly[1] = next_bit();
                dly[0] = next_bit();
                mem_busy = 1'b1;
                mem_addr = imem_addr;
                mem_wait = int'(dly) + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("Timeout after %0d cycles, entries stopped arriving", cycles);
            $display("Test failed");
            $finish;
        end
    end

    task automatic check_field(string field, word_t exp, word_t act);
        test_checks++;
        if (exp !== act) begin
            $display("Fail %s %s expected %h actual %h", test_name, field, exp, act);
            test_errs++;
        end
    endtask

    task automatic expect_entry(cmd_t e);
        bht_idx_t idx;
        logic     got;
        idx = e.a[`BHT_LSB +: `BHT_IDX_W];
        if (e.c[6:0] == 7'b1100011 && ref_ctr[idx][1] != e.d[0]) begin
            $display("%s: expected taken bit at %h disagrees with counter model",
                     test_name, e.a);
            test_errs++;
        end
        got = 1'b0;
        while (!got) begin
            @(posedge clk);
            iq_ready <= next_bit();
            @(negedge clk);
            if (iq_valid && iq_ready) begin
                check_field("pc", e.a, iq_pc);
                check_field("next_pc", e.b, iq_next_pc);
                check_field("instr", e.c, iq_instr);
                check_field("pred_taken", e.d, word_t'(iq_pred_taken));
                got = 1'b1;
            end
        end
        @(posedge clk);
        iq_ready <= 1'b0;
    endtask

    task automatic redirect_to(word_t pc);
        @(posedge clk);
        redirect_valid <= 1'b1;
        redirect_pc    <= pc;
        @(posedge clk);
        redirect_valid <= 1'b0;
    endtask

    task automatic train(word_t pc, logic taken);
        bht_idx_t idx;
        idx = pc[`BHT_LSB +: `BHT_IDX_W];
        @(posedge clk);
        bu_valid <= 1'b1;
        bu_pc    <= pc;
        bu_taken <= taken;
        @(posedge clk);
        bu_valid <= 1'b0;
        if (taken && ref_ctr[idx] != 2'd3) begin
            ref_ctr[idx] = ref_ctr[idx] + 2'd1;
        end else if (!taken && ref_ctr[idx] != 2'd0) begin
            ref_ctr[idx] = ref_ctr[idx] - 2'd1;
        end
    endtask

    task automatic read_commands();
        int    fd;
        int    r;
        string tok;
        string line;
        cmd_t  c;
        fd = $fopen("bench/ifetch_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open bench/ifetch_input.txt");
            total_errs++;
            return;
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            c.kind = tok;
            c.d    = '0;
            r      = 1;
            case (tok)
                "#": r = $fgets(line, fd);
                "M": begin
                    r = $fscanf(fd, "%h %h", c.a, c.b);
                    mem[c.a] = c.b;
                end
                "T": r = $fscanf(fd, "%s", c.name);
                "R": r = $fscanf(fd, "%h", c.a);
                "U": r = $fscanf(fd, "%h %d", c.a, c.d);
                "E": r = $fscanf(fd, "%h %h %h %d", c.a, c.b, c.c, c.d);
                "H": r = $fscanf(fd, "%d", c.a);
                "X": r = 1;
                default: begin
                    $display("Unknown command %s in stimulus file", tok);
                    total_errs++;
                end
            endcase
            if (r <= 0) begin
                $display("Missing fields after %s in stimulus file", tok);
                total_errs++;
            end
            if (tok != "#" && tok != "M") begin
                cmds.push_back(c);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int budget;
        rst_n          = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        iq_ready       = 1'b0;
        bu_valid       = 1'b0;
        bu_pc          = '0;
        bu_taken       = 1'b0;
        imem_valid     = 1'b0;
        imem_rdata     = '0;
        cycles         = 0;
        foreach (ref_ctr[i]) begin
            ref_ctr[i] = 2'd1;
        end
        read_commands();
        budget = 200;
        foreach (cmds[i]) begin
            if (cmds[i].kind == "E") begin
                budget += 16;
            end else if (cmds[i].kind == "H") begin
                budget += int'(cmds[i].a);
            end
        end
        limit = budget;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        foreach (cmds[i]) begin
            case (cmds[i].kind)
                "T": begin
                    test_name   = cmds[i].name;
                    test_errs   = 0;
                    test_checks = 0;
                end
                "R": redirect_to(cmds[i].a);
                "U": train(cmds[i].a, cmds[i].d[0]);
                "E": expect_entry(cmds[i]);
                "H": repeat (int'(cmds[i].a)) @(posedge clk);
                "X": begin
                    $display("test %s done, %0d checks, %0d errors",
                             test_name, test_checks, test_errs);
                    tests_run++;
                    total_errs += test_errs;
                    if (test_errs != 0) begin
                        tests_bad++;
                    end
                end
                default: ;
            endcase
        end

        $display("%0d tests, %0d with errors, %0d errors in all",
                 tests_run, tests_bad, total_errs);
        if (total_errs == 0 && tests_run > 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/ifetch_input.txt */
# M addr instr | T name | R pc | U pc taken | H cycles | X end of test
# E pc next_pc instr pred_taken (expected dequeued entry)
M 0 00000013
M 4 00100093
M 8 00200113
M c 00300193
M 100 00000013
M 104 0200006f
M 124 00500293
M 200 00000013
M 204 00100093
M 208 fe000ce3
T straight
E 0 4 00000013 0
E 4 8 00100093 0
E 8 c 00200113 0
E c 10 00300193 0
X
T jal
R 100
E 100 104 00000013 0
E 104 124 0200006f 1
E 124 128 00500293 0
X
T branch
R 200
E 200 204 00000013 0
E 204 208 00100093 0
E 208 20c fe000ce3 0
U 208 1
U 208 1
R 208
E 208 200 fe000ce3 1
E 200 204 00000013 0
U 208 0
U 208 0
R 208
E 208 20c fe000ce3 0
X
T redirect
R 300
E 300 304 00006013 0
E 304 308 00006093 0
R 400
E 400 404 00008013 0
E 404 408 00008093 0
E 408 40c 00008113 0
X
T stall
R 500
H 40
E 500 504 0000a013 0
E 504 508 0000a093 0
E 508 50c 0000a113 0
E 50c 510 0000a193 0
E 510 514 0000a213 0
E 514 518 0000a293 0
X

/* ifetch.f */
+incdir+source
source/fetch_pkg.sv
source/iq_entry_if.sv
source/pred_if.sv
source/fetch_ctrl.sv
source/branch_predictor.sv
source/instr_queue.sv
source/ifetch_top.sv
bench/tb_ifetch.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -f ifetch.f --top-module tb_ifetch -o vtb_ifetch
	./obj_dir/vtb_ifetch | tee /dev/stderr | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
